/* design/mmu_pkg.sv */
package mmu_pkg;

	//--------------------------------------------------------------------------
	// widths with a meaning
	//--------------------------------------------------------------------------
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [19:0] ppn_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// address presented downstream by the walker
	typedef enum logic [1:0] {
		SEL_PTE1,
		SEL_PTE0,
		SEL_PHYS
	} walk_sel_t;

	//--------------------------------------------------------------------------
	// controller states
	//--------------------------------------------------------------------------
	typedef enum logic [3:0] {
		IDLE,
		BYP_RD,
		BYP_WR,
		WALK_AR,
		WALK_R,
		ACC_AR,
		ACC_R,
		ACC_AW_W,
		ACC_B,
		RESP_R,
		RESP_B
	} ctrl_state_t;

endpackage

/* design/mmu_ctrl.sv */
`timescale 1ns/1ps

module mmu_ctrl (
	input  logic                 clk,
	input  logic                 rst,
	input  mmu_pkg::data_t       satp,
	input  logic                 s_arvalid,
	input  logic                 s_awvalid,
	input  logic                 s_wvalid,
	input  logic                 s_rready,
	input  logic                 s_bready,
	input  logic                 m_arready,
	input  logic                 m_rvalid,
	input  logic                 m_awready,
	input  logic                 m_wready,
	input  logic                 m_bvalid,
	input  logic                 pte_valid,
	output mmu_pkg::ctrl_state_t state,
	output mmu_pkg::walk_sel_t   walk_sel,
	output logic                 t_arready,
	output logic                 t_awready,
	output logic                 t_wready,
	output logic                 t_rvalid,
	output logic                 t_bvalid,
	output logic                 w_arvalid,
	output logic                 w_rready,
	output logic                 w_awvalid,
	output logic                 w_wvalid,
	output logic                 w_bready,
	output logic                 cap_req,
	output logic                 cap_pte1,
	output logic                 cap_pte0,
	output logic                 cap_rdata,
	output logic                 cap_bresp,
	output logic                 set_fault
);

	mmu_pkg::ctrl_state_t state_next;
	mmu_pkg::walk_sel_t   walk_sel_next;
	logic                 is_write;
	logic                 aw_done;
	logic                 w_done;
	logic                 wr_req;

	// writes win when both directions are pending
	assign wr_req = s_awvalid && s_wvalid;

	//--------------------------------------------------------------------------
	// registers
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= mmu_pkg::IDLE;
			walk_sel <= mmu_pkg::SEL_PTE1;
			is_write <= 1'b0;
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
		end else begin
			state    <= state_next;
			walk_sel <= walk_sel_next;
			if (cap_req)
				is_write <= t_awready;
			// handshake tracking only lives inside ACC_AW_W
			if (state != mmu_pkg::ACC_AW_W || state_next != mmu_pkg::ACC_AW_W) begin
				aw_done <= 1'b0;
				w_done  <= 1'b0;
			end else begin
				aw_done <= aw_done | m_awready;
				w_done  <= w_done | m_wready;
			end
		end
	end

	//--------------------------------------------------------------------------
	// next state and outputs
	//--------------------------------------------------------------------------
	always_comb begin
		state_next    = state;
		walk_sel_next = walk_sel;
		t_arready     = 1'b0;
		t_awready     = 1'b0;
		t_wready      = 1'b0;
		t_rvalid      = 1'b0;
		t_bvalid      = 1'b0;
		w_arvalid     = 1'b0;
		w_rready      = 1'b0;
		w_awvalid     = 1'b0;
		w_wvalid      = 1'b0;
		w_bready      = 1'b0;
		cap_req       = 1'b0;
		cap_pte1      = 1'b0;
		cap_pte0      = 1'b0;
		cap_rdata     = 1'b0;
		cap_bresp     = 1'b0;
		set_fault     = 1'b0;
		case (state)
			mmu_pkg::IDLE: begin
				if (!satp[31]) begin
					if (wr_req)
						state_next = mmu_pkg::BYP_WR;
					else if (s_arvalid)
						state_next = mmu_pkg::BYP_RD;
				end else if (wr_req || s_arvalid) begin
					// accept the request in this cycle, walk starts at level 1
					t_awready     = wr_req;
					t_wready      = wr_req;
					t_arready     = !wr_req;
					cap_req       = 1'b1;
					walk_sel_next = mmu_pkg::SEL_PTE1;
					state_next    = mmu_pkg::WALK_AR;
				end
			end
			mmu_pkg::BYP_RD: if (m_rvalid && s_rready) state_next = mmu_pkg::IDLE;
			mmu_pkg::BYP_WR: if (m_bvalid && s_bready) state_next = mmu_pkg::IDLE;
			mmu_pkg::WALK_AR: begin
				w_arvalid = 1'b1;
				if (m_arready)
					state_next = mmu_pkg::WALK_R;
			end
			mmu_pkg::WALK_R: begin
				w_rready = 1'b1;
				if (m_rvalid) begin
					if (!pte_valid) begin
						set_fault  = 1'b1;
						state_next = is_write ? mmu_pkg::RESP_B : mmu_pkg::RESP_R;
					end else if (walk_sel == mmu_pkg::SEL_PTE1) begin
						cap_pte1      = 1'b1;
						walk_sel_next = mmu_pkg::SEL_PTE0;
						state_next    = mmu_pkg::WALK_AR;
					end else begin
						cap_pte0      = 1'b1;
						walk_sel_next = mmu_pkg::SEL_PHYS;
						state_next    = is_write ? mmu_pkg::ACC_AW_W : mmu_pkg::ACC_AR;
					end
				end
			end
			mmu_pkg::ACC_AR: begin
				w_arvalid = 1'b1;
				if (m_arready)
					state_next = mmu_pkg::ACC_R;
			end
			mmu_pkg::ACC_R: begin
				w_rready = 1'b1;
				if (m_rvalid) begin
					cap_rdata  = 1'b1;
					state_next = mmu_pkg::RESP_R;
				end
			end
			mmu_pkg::ACC_AW_W: begin
				// aw and w may complete in either order
				w_awvalid = !aw_done;
				w_wvalid  = !w_done;
				if ((aw_done || m_awready) && (w_done || m_wready))
					state_next = mmu_pkg::ACC_B;
			end
			mmu_pkg::ACC_B: begin
				w_bready = 1'b1;
				if (m_bvalid) begin
					cap_bresp  = 1'b1;
					state_next = mmu_pkg::RESP_B;
				end
			end
			mmu_pkg::RESP_R: begin
				t_rvalid = 1'b1;
				if (s_rready)
					state_next = mmu_pkg::IDLE;
			end
			mmu_pkg::RESP_B: begin
				t_bvalid = 1'b1;
				if (s_bready)
					state_next = mmu_pkg::IDLE;
			end
			default: state_next = mmu_pkg::IDLE;
		endcase
	end

endmodule

/* design/mmu_walk_regs.sv */
`timescale 1ns/1ps

module mmu_walk_regs (
	input  logic                clk,
	input  logic                rst,
	input  mmu_pkg::data_t      satp,
	input  mmu_pkg::addr_t      s_araddr,
	input  mmu_pkg::addr_t      s_awaddr,
	input  mmu_pkg::data_t      s_wdata,
	input  logic [3:0]          s_wstrb,
	input  mmu_pkg::data_t      m_rdata,
	input  mmu_pkg::resp_t      m_rresp,
	input  mmu_pkg::resp_t      m_bresp,
	input  logic                cap_req,
	input  logic                cap_pte1,
	input  logic                cap_pte0,
	input  logic                cap_rdata,
	input  logic                cap_bresp,
	input  logic                set_fault,
	input  logic                is_write,
	input  mmu_pkg::walk_sel_t  walk_sel,
	output mmu_pkg::addr_t      walk_addr,
	output logic                pte_valid,
	output mmu_pkg::data_t      w_data,
	output logic [3:0]          w_strb,
	output mmu_pkg::data_t      r_data,
	output mmu_pkg::resp_t      r_resp,
	output mmu_pkg::resp_t      b_resp
);

	mmu_pkg::ppn_t  root_ppn;
	mmu_pkg::ppn_t  pte1_ppn;
	mmu_pkg::ppn_t  pte0_ppn;
	mmu_pkg::addr_t vaddr;

	assign pte_valid = m_rdata[0];

	// request payload and PTE page numbers
	always_ff @(posedge clk) begin
		if (cap_req) begin
			root_ppn <= satp[19:0];
			vaddr    <= is_write ? s_awaddr : s_araddr;
			w_data   <= s_wdata;
			w_strb   <= s_wstrb;
		end
		if (cap_pte1)
			pte1_ppn <= m_rdata[29:10];
		if (cap_pte0)
			pte0_ppn <= m_rdata[29:10];
	end

	// held responses, a fault overrides whatever came back
	always_ff @(posedge clk) begin
		if (rst) begin
			r_data <= '0;
			r_resp <= mmu_pkg::RESP_OKAY;
			b_resp <= mmu_pkg::RESP_OKAY;
		end else if (set_fault) begin
			r_data <= '0;
			r_resp <= mmu_pkg::RESP_SLVERR;
			b_resp <= mmu_pkg::RESP_SLVERR;
		end else begin
			if (cap_rdata) begin
				r_data <= m_rdata;
				r_resp <= m_rresp;
			end
			if (cap_bresp)
				b_resp <= m_bresp;
		end
	end

	//--------------------------------------------------------------------------
	// Sv32 walk addresses
	//--------------------------------------------------------------------------
	always_comb begin
		case (walk_sel)
			mmu_pkg::SEL_PTE1: walk_addr = {root_ppn, vaddr[31:22], 2'b00};
			mmu_pkg::SEL_PTE0: walk_addr = {pte1_ppn, vaddr[21:12], 2'b00};
			default:           walk_addr = {pte0_ppn, vaddr[11:0]};
		endcase
	end

endmodule

/* design/mmu_bus_mux.sv */
`timescale 1ns/1ps

module mmu_bus_mux (
	input  mmu_pkg::ctrl_state_t state,
	// upstream
	input  mmu_pkg::addr_t       s_araddr,
	input  logic                 s_arvalid,
	output logic                 s_arready,
	output mmu_pkg::data_t       s_rdata,
	output mmu_pkg::resp_t       s_rresp,
	output logic                 s_rvalid,
	input  logic                 s_rready,
	input  mmu_pkg::addr_t       s_awaddr,
	input  logic                 s_awvalid,
	output logic                 s_awready,
	input  mmu_pkg::data_t       s_wdata,
	input  logic [3:0]           s_wstrb,
	input  logic                 s_wvalid,
	output logic                 s_wready,
	output mmu_pkg::resp_t       s_bresp,
	output logic                 s_bvalid,
	input  logic                 s_bready,
	// downstream
	output mmu_pkg::addr_t       m_araddr,
	output logic                 m_arvalid,
	input  logic                 m_arready,
	input  mmu_pkg::data_t       m_rdata,
	input  mmu_pkg::resp_t       m_rresp,
	input  logic                 m_rvalid,
	output logic                 m_rready,
	output mmu_pkg::addr_t       m_awaddr,
	output logic                 m_awvalid,
	input  logic                 m_awready,
	output mmu_pkg::data_t       m_wdata,
	output logic [3:0]           m_wstrb,
	output logic                 m_wvalid,
	input  logic                 m_wready,
	input  mmu_pkg::resp_t       m_bresp,
	input  logic                 m_bvalid,
	output logic                 m_bready,
	// walker side
	input  logic                 t_arready,
	input  logic                 t_awready,
	input  logic                 t_wready,
	input  logic                 t_rvalid,
	input  logic                 t_bvalid,
	input  logic                 w_arvalid,
	input  logic                 w_rready,
	input  logic                 w_awvalid,
	input  logic                 w_wvalid,
	input  logic                 w_bready,
	input  mmu_pkg::addr_t       walk_addr,
	input  mmu_pkg::data_t       w_data,
	input  logic [3:0]           w_strb,
	input  mmu_pkg::data_t       r_data,
	input  mmu_pkg::resp_t       r_resp,
	input  mmu_pkg::resp_t       b_resp
);

	logic byp_rd;
	logic byp_wr;
	logic busy;

	assign byp_rd = state == mmu_pkg::BYP_RD;
	assign byp_wr = state == mmu_pkg::BYP_WR;
	// nothing moves downstream or back upstream while idle
	assign busy   = state != mmu_pkg::IDLE;

	// read direction
	assign m_araddr  = byp_rd ? s_araddr : walk_addr;
	assign m_arvalid = byp_rd ? s_arvalid : busy && w_arvalid;
	assign s_arready = byp_rd ? m_arready : t_arready;
	assign m_rready  = byp_rd ? s_rready : busy && w_rready;
	assign s_rvalid  = byp_rd ? m_rvalid : busy && t_rvalid;
	assign s_rdata   = byp_rd ? m_rdata : r_data;
	assign s_rresp   = byp_rd ? m_rresp : r_resp;

	// write direction
	assign m_awaddr  = byp_wr ? s_awaddr : walk_addr;
	assign m_awvalid = byp_wr ? s_awvalid : busy && w_awvalid;
	assign s_awready = byp_wr ? m_awready : t_awready;
	assign m_wdata   = byp_wr ? s_wdata : w_data;
	assign m_wstrb   = byp_wr ? s_wstrb : w_strb;
	assign m_wvalid  = byp_wr ? s_wvalid : busy && w_wvalid;
	assign s_wready  = byp_wr ? m_wready : t_wready;
	assign m_bready  = byp_wr ? s_bready : busy && w_bready;
	assign s_bvalid  = byp_wr ? m_bvalid : busy && t_bvalid;
	assign s_bresp   = byp_wr ? m_bresp : b_resp;

endmodule

/* design/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top (
	input  logic           clk,
	input  logic           rst,
	input  mmu_pkg::data_t satp,
	// upstream, from the load/store port
	input  mmu_pkg::addr_t s_araddr,
	input  logic           s_arvalid,
	output logic           s_arready,
	output mmu_pkg::data_t s_rdata,
	output mmu_pkg::resp_t s_rresp,
	output logic           s_rvalid,
	input  logic           s_rready,
	input  mmu_pkg::addr_t s_awaddr,
	input  logic           s_awvalid,
	output logic           s_awready,
	input  mmu_pkg::data_t s_wdata,
	input  logic [3:0]     s_wstrb,
	input  logic           s_wvalid,
	output logic           s_wready,
	output mmu_pkg::resp_t s_bresp,
	output logic           s_bvalid,
	input  logic           s_bready,
	// downstream, to memory
	output mmu_pkg::addr_t m_araddr,
	output logic           m_arvalid,
	input  logic           m_arready,
	input  mmu_pkg::data_t m_rdata,
	input  mmu_pkg::resp_t m_rresp,
	input  logic           m_rvalid,
	output logic           m_rready,
	output mmu_pkg::addr_t m_awaddr,
	output logic           m_awvalid,
	input  logic           m_awready,
	output mmu_pkg::data_t m_wdata,
	output logic [3:0]     m_wstrb,
	output logic           m_wvalid,
	input  logic           m_wready,
	input  mmu_pkg::resp_t m_bresp,
	input  logic           m_bvalid,
	output logic           m_bready
);

	mmu_pkg::ctrl_state_t state;
	mmu_pkg::walk_sel_t   walk_sel;
	mmu_pkg::addr_t       walk_addr;
	mmu_pkg::data_t       w_data;
	mmu_pkg::data_t       r_data;
	mmu_pkg::resp_t       r_resp;
	mmu_pkg::resp_t       b_resp;
	logic [3:0]           w_strb;
	logic                 pte_valid;
	logic                 t_arready, t_awready, t_wready, t_rvalid, t_bvalid;
	logic                 w_arvalid, w_rready, w_awvalid, w_wvalid, w_bready;
	logic                 cap_req, cap_pte1, cap_pte0, cap_rdata, cap_bresp, set_fault;

	mmu_ctrl mmu_ctrl_inst (.*);

	// a write is accepted exactly when the controller raises awready
	mmu_walk_regs mmu_walk_regs_inst (
		.is_write (t_awready),
		.*
	);

	mmu_bus_mux mmu_bus_mux_inst (.*);

endmodule

/* tb/tb_mmu_mem.sv */
`timescale 1ns/1ps

module tb_mmu_mem (
	input  logic           clk,
	input  logic           rst,
	input  mmu_pkg::addr_t araddr,
	input  logic           arvalid,
	output logic           arready,
	output mmu_pkg::data_t rdata,
	output mmu_pkg::resp_t rresp,
	output logic           rvalid,
	input  logic           rready,
	input  mmu_pkg::addr_t awaddr,
	input  logic           awvalid,
	output logic           awready,
	input  mmu_pkg::data_t wdata,
	input  logic [3:0]     wstrb,
	input  logic           wvalid,
	output logic           wready,
	output mmu_pkg::resp_t bresp,
	output logic           bvalid,
	input  logic           bready
);

	// 256 KB of words, indexed by address bits 17:2
	mmu_pkg::data_t mem [0:65535];
	integer         seed = 42654;
	mmu_pkg::addr_t rd_addr;
	mmu_pkg::addr_t wr_addr;
	mmu_pkg::data_t wr_data;
	logic [3:0]     wr_strb;
	logic           rd_busy;
	logic           aw_got;
	logic           w_got;
	logic [1:0]     acnt;
	logic [1:0]     rcnt;
	logic [1:0]     awcnt;
	logic [1:0]     wcnt;
	logic [1:0]     bcnt;
	logic [31:0]    mask;

	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = {~i[15:0], i[15:0] ^ 16'h3c5a};
	end

	function automatic logic [1:0] delay();
		logic [31:0] r;
		r = $random(seed);
		return r[1:0];
	endfunction

	task automatic poke(input mmu_pkg::addr_t a, input mmu_pkg::data_t d);
		mem[a[17:2]] = d;
	endtask

	task automatic peek(input mmu_pkg::addr_t a, output mmu_pkg::data_t d);
		d = mem[a[17:2]];
	endtask

	assign rresp = mmu_pkg::RESP_OKAY;
	assign bresp = mmu_pkg::RESP_OKAY;
	assign mask  = {{8{wr_strb[3]}}, {8{wr_strb[2]}}, {8{wr_strb[1]}}, {8{wr_strb[0]}}};

	//------------------------------------------------------------------------
	// read side, ar then r
	//------------------------------------------------------------------------
	always @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rd_busy <= 1'b0;
			acnt    <= 2'd0;
			rcnt    <= 2'd0;
		end else if (!rd_busy) begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				rd_addr <= araddr;
				rd_busy <= 1'b1;
				rcnt    <= delay();
			end else if (arvalid) begin
				if (acnt == 2'd0)
					arready <= 1'b1;
				else
					acnt <= acnt - 2'd1;
			end
		end else if (rvalid) begin
			if (rready) begin
				rvalid  <= 1'b0;
				rd_busy <= 1'b0;
				acnt    <= delay();
			end
		end else if (rcnt == 2'd0) begin
			rvalid <= 1'b1;
			rdata  <= mem[rd_addr[17:2]];
		end else begin
			rcnt <= rcnt - 2'd1;
		end
	end

	//------------------------------------------------------------------------
	// write side, aw and w in any order, then b
	//------------------------------------------------------------------------
	always @(posedge clk) begin
		if (rst) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
			awcnt   <= 2'd0;
			wcnt    <= 2'd0;
			bcnt    <= 2'd0;
		end else begin
			if (awvalid && awready) begin
				awready <= 1'b0;
				aw_got  <= 1'b1;
				wr_addr <= awaddr;
			end else if (awvalid && !aw_got) begin
				if (awcnt == 2'd0)
					awready <= 1'b1;
				else
					awcnt <= awcnt - 2'd1;
			end
			if (wvalid && wready) begin
				wready  <= 1'b0;
				w_got   <= 1'b1;
				wr_data <= wdata;
				wr_strb <= wstrb;
			end else if (wvalid && !w_got) begin
				if (wcnt == 2'd0)
					wready <= 1'b1;
				else
					wcnt <= wcnt - 2'd1;
			end
			if (bvalid) begin
				if (bready) begin
					bvalid <= 1'b0;
					aw_got <= 1'b0;
					w_got  <= 1'b0;
					awcnt  <= delay();
					wcnt   <= delay();
					bcnt   <= delay();
				end
			end else if (aw_got && w_got) begin
				if (bcnt == 2'd0) begin
					mem[wr_addr[17:2]] = (mem[wr_addr[17:2]] & ~mask) | (wr_data & mask);
					bvalid <= 1'b1;
				end else begin
					bcnt <= bcnt - 2'd1;
				end
			end
		end
	end

endmodule

/* tb/tb_mmu.sv */
`timescale 1ns/1ps

module tb_mmu;

	logic           clk;
	logic           rst;
	mmu_pkg::data_t satp;
	mmu_pkg::addr_t s_araddr, s_awaddr, m_araddr, m_awaddr;
	mmu_pkg::data_t s_rdata, s_wdata, m_rdata, m_wdata;
	mmu_pkg::resp_t s_rresp, s_bresp, m_rresp, m_bresp;
	logic [3:0]     s_wstrb, m_wstrb;
	logic           s_arvalid, s_arready, s_rvalid, s_rready;
	logic           s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
	logic           m_arvalid, m_arready, m_rvalid, m_rready;
	logic           m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;

	integer         seed = 42654;
	logic           started = 1'b0;
	// expected downstream addresses, in handshake order
	mmu_pkg::addr_t exp_ar [0:255];
	mmu_pkg::addr_t exp_aw [0:255];
	logic [7:0]     ar_cnt = 8'd0;
	logic [7:0]     ar_idx = 8'd0;
	logic [7:0]     aw_cnt = 8'd0;
	logic [7:0]     aw_idx = 8'd0;
	mmu_pkg::data_t exp_rdata;
	mmu_pkg::resp_t exp_rresp;
	mmu_pkg::resp_t exp_bresp;
	logic           mem_chk = 1'b0;
	mmu_pkg::addr_t mem_addr;
	mmu_pkg::data_t mem_got, mem_exp;
	// own copy of every PTE placed in memory
	mmu_pkg::data_t pt_copy [mmu_pkg::addr_t];

	mmu_top mmu_top_inst (.*);

	tb_mmu_mem mem_inst (
		.clk(clk), .rst(rst),
		.araddr(m_araddr), .arvalid(m_arvalid), .arready(m_arready),
		.rdata(m_rdata), .rresp(m_rresp), .rvalid(m_rvalid), .rready(m_rready),
		.awaddr(m_awaddr), .awvalid(m_awvalid), .awready(m_awready),
		.wdata(m_wdata), .wstrb(m_wstrb), .wvalid(m_wvalid), .wready(m_wready),
		.bresp(m_bresp), .bvalid(m_bvalid), .bready(m_bready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	initial begin
		repeat (40 * 60) @(posedge clk);
		$display("watchdog expired before the test sequence finished");
		abort_run();
	end

	always @(posedge clk) begin
		if (m_arvalid && m_arready)
			ar_idx <= ar_idx + 8'd1;
		if (m_awvalid && m_awready)
			aw_idx <= aw_idx + 8'd1;
	end

	//------------------------------------------------------------------------
	// checks
	//------------------------------------------------------------------------
	assert property (@(posedge clk) disable iff (rst) !started |-> !(s_arready || s_awready
		|| s_wready || s_rvalid || s_bvalid || m_arvalid || m_awvalid || m_wvalid))
	else begin
		$display("handshake signal went high before the first request");
		abort_run();
	end

	assert property (@(posedge clk) disable iff (rst) m_arvalid |-> ar_idx < ar_cnt)
	else begin
		$display("downstream read issued when none was expected");
		abort_run();
	end

	assert property (@(posedge clk) disable iff (rst) m_awvalid |-> aw_idx < aw_cnt)
	else begin
		$display("downstream write issued when none was expected");
		abort_run();
	end

	assert property (@(posedge clk) disable iff (rst)
		m_arvalid && m_arready |-> m_araddr == exp_ar[ar_idx])
	else begin
		$display("ERR m_araddr got %h exp %h", $sampled(m_araddr),
			exp_ar[$sampled(ar_idx)]);
		abort_run();
	end

	assert property (@(posedge clk) disable iff (rst)
		m_awvalid && m_awready |-> m_awaddr == exp_aw[aw_idx])
	else begin
		$display("ERR m_awaddr got %h exp %h", $sampled(m_awaddr),
			exp_aw[$sampled(aw_idx)]);
		abort_run();
	end

	assert property (@(posedge clk) disable iff (rst)
		s_rvalid && s_rready |-> s_rdata == exp_rdata)
	else begin
		$display("ERR s_rdata got %h exp %h", $sampled(s_rdata), exp_rdata);
		abort_run();
	end

	assert property (@(posedge clk) disable iff (rst)
		s_rvalid && s_rready |-> s_rresp == exp_rresp)
	else begin
		$display("ERR s_rresp got %h exp %h", $sampled(s_rresp), exp_rresp);
		abort_run();
	end

	assert property (@(posedge clk) disable iff (rst)
		s_bvalid && s_bready |-> s_bresp == exp_bresp)
	else begin
		$display("ERR s_bresp got %h exp %h", $sampled(s_bresp), exp_bresp);
		abort_run();
	end

	assert property (@(posedge clk) disable iff (rst)
		s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp))
	else begin
		$display("read response changed before its handshake");
		abort_run();
	end

	assert property (@(posedge clk) disable iff (rst)
		s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
	else begin
		$display("write response changed before its handshake");
		abort_run();
	end

	assert property (@(posedge clk) mem_chk |-> mem_got == mem_exp)
	else begin
		$display("ERR mem[%h] got %h exp %h", mem_addr, mem_got, mem_exp);
		abort_run();
	end

	//------------------------------------------------------------------------
	// helpers
	//------------------------------------------------------------------------
	function automatic logic [31:0] rnd();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	function automatic logic [3:0] rnd_strb();
		logic [31:0] r;
		r = rnd();
		return r[3:0];
	endfunction

	function automatic mmu_pkg::data_t merge(mmu_pkg::data_t old, mmu_pkg::data_t d,
		logic [3:0] st);
		logic [31:0] m;
		m = {{8{st[3]}}, {8{st[2]}}, {8{st[1]}}, {8{st[0]}}};
		return (old & ~m) | (d & m);
	endfunction

	task automatic place_pte(input mmu_pkg::addr_t a, input logic [19:0] ppn, input logic v);
		mmu_pkg::data_t pte;
		pte = {2'b00, ppn, 9'd0, v};
		pt_copy[a] = pte;
		mem_inst.poke(a, pte);
	endtask

	function automatic mmu_pkg::data_t pte_at(mmu_pkg::addr_t a);
		return pt_copy.exists(a) ? pt_copy[a] : 32'd0;
	endfunction

	task automatic expect_ar(input mmu_pkg::addr_t a);
		exp_ar[ar_cnt] = a;
		ar_cnt = ar_cnt + 8'd1;
	endtask

	// Sv32 walk on the local copy, queues the expected reads, returns pa
	task automatic plan_access(input mmu_pkg::addr_t va, output mmu_pkg::addr_t pa,
		output logic fault);
		mmu_pkg::addr_t a1, a0;
		mmu_pkg::data_t p1, p0;
		fault = 1'b0;
		pa    = va;
		if (satp[31]) begin
			a1 = {satp[19:0], va[31:22], 2'b00};
			p1 = pte_at(a1);
			expect_ar(a1);
			a0 = {p1[29:10], va[21:12], 2'b00};
			p0 = pte_at(a0);
			if (!p1[0]) begin
				fault = 1'b1;
			end else begin
				expect_ar(a0);
				fault = !p0[0];
			end
			pa = {p0[29:10], va[11:0]};
		end
	endtask

	task automatic check_mem(input mmu_pkg::addr_t a, input mmu_pkg::data_t e);
		mem_addr = a;
		mem_exp  = e;
		mem_inst.peek(a, mem_got);
		mem_chk  = 1'b1;
		@(posedge clk);
		#1 mem_chk = 1'b0;
	endtask

	task automatic read_txn(input mmu_pkg::addr_t va);
		mmu_pkg::addr_t pa;
		logic           fault;
		logic           hs;
		plan_access(va, pa, fault);
		exp_rdata = '0;
		exp_rresp = fault ? mmu_pkg::RESP_SLVERR : mmu_pkg::RESP_OKAY;
		if (!fault) begin
			expect_ar(pa);
			mem_inst.peek(pa, exp_rdata);
		end
		started   = 1'b1;
		s_araddr  = va;
		s_arvalid = 1'b1;
		do begin
			@(negedge clk);
			hs = s_arvalid && s_arready;
			@(posedge clk);
			#1;
		end while (!hs);
		s_arvalid = 1'b0;
		// random low periods on rready
		do begin
			s_rready = rnd() % 2 == 0;
			@(negedge clk);
			hs = s_rvalid && s_rready;
			@(posedge clk);
			#1;
		end while (!hs);
		s_rready = 1'b0;
	endtask

	task automatic write_txn(input mmu_pkg::addr_t va, input mmu_pkg::data_t d,
		input logic [3:0] st);
		mmu_pkg::addr_t pa;
		mmu_pkg::data_t old;
		logic           fault;
		logic           hs_aw, hs_w, hs_b;
		plan_access(va, pa, fault);
		exp_bresp = fault ? mmu_pkg::RESP_SLVERR : mmu_pkg::RESP_OKAY;
		mem_inst.peek(pa, old);
		if (!fault) begin
			exp_aw[aw_cnt] = pa;
			aw_cnt = aw_cnt + 8'd1;
		end
		started   = 1'b1;
		s_awaddr  = va;
		s_wdata   = d;
		s_wstrb   = st;
		s_awvalid = 1'b1;
		s_wvalid  = 1'b1;
		while (s_awvalid || s_wvalid) begin
			@(negedge clk);
			hs_aw = s_awvalid && s_awready;
			hs_w  = s_wvalid && s_wready;
			@(posedge clk);
			#1;
			if (hs_aw)
				s_awvalid = 1'b0;
			if (hs_w)
				s_wvalid = 1'b0;
		end
		do begin
			s_bready = rnd() % 2 == 0;
			@(negedge clk);
			hs_b = s_bvalid && s_bready;
			@(posedge clk);
			#1;
		end while (!hs_b);
		s_bready = 1'b0;
		// a faulting write must leave the walked-to word alone
		check_mem(pa, fault ? old : merge(old, d, st));
	endtask

	function automatic mmu_pkg::addr_t mapped_va();
		logic [31:0] r;
		logic [9:0]  vpn1, vpn0;
		r    = rnd();
		vpn1 = r[0] ? 10'd1 : 10'd3;
		vpn0 = r[0] ? {7'd0, r[4:2]} : {8'd0, r[6:5]};
		return {vpn1, vpn0, r[19:10], 2'b00};
	endfunction

	//------------------------------------------------------------------------
	// test sequence
	//------------------------------------------------------------------------
	initial begin
		mmu_pkg::addr_t a;
		mmu_pkg::data_t d;
		rst = 1'b1;
		satp = '0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		// root at 0x10000, level-0 tables at 0x11000 and 0x12000
		place_pte(32'h0001_0004, 20'h00011, 1'b1);
		place_pte(32'h0001_0008, 20'h00000, 1'b0);
		place_pte(32'h0001_000c, 20'h00012, 1'b1);
		for (int i = 0; i < 8; i++)
			place_pte(32'h0001_1000 + 4 * i, 20'h00020 + 20'(i), 1'b1);
		place_pte(32'h0001_1020, 20'h00000, 1'b0);
		for (int i = 0; i < 4; i++)
			place_pte(32'h0001_2000 + 4 * i, 20'h00028 + 20'(i), 1'b1);
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
		repeat (6) @(posedge clk);
		#1;

		// bypass in the 0x30000 region
		for (int i = 0; i < 4; i++) begin
			d = rnd();
			a = {14'd0, 2'b11, d[15:2], 2'b00};
			read_txn(a);
			write_txn(a, rnd(), rnd_strb());
			read_txn(a);
		end

		satp = 32'h8000_0010;
		for (int i = 0; i < 8; i++)
			read_txn(mapped_va());
		for (int i = 0; i < 8; i++) begin
			a = mapped_va();
			write_txn(a, rnd(), rnd_strb());
			read_txn(a);
		end

		// invalid PTE1, then invalid PTE0
		read_txn(32'h0080_0010);
		write_txn(32'h0080_0020, 32'hdead_beef, 4'hf);
		read_txn(32'h0040_8004);
		write_txn(32'h0040_8008, 32'hcafe_f00d, 4'hf);

		repeat (4) @(posedge clk);
		$display("Everything OK");
		$finish;
	end

endmodule

/* sources.f */
design/mmu_pkg.sv
design/mmu_ctrl.sv
design/mmu_walk_regs.sv
design/mmu_bus_mux.sv
design/mmu_top.sv
tb/tb_mmu_mem.sv
tb/tb_mmu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mmu
VFLAGS    ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP VFLAGS OBJ_DIR"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sources.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
